// ==== logic/vnu_config.svh ====
`ifndef VNU_CONFIG_SVH
`define VNU_CONFIG_SVH

// flops in the iteration phase synchroniser
// 2 by default and 3 also works
`define VNU_CDC_DEPTH 2

// decomposed lut entries per pass
`define VNU_LUT_DEPTH 8

// address width for the entries above
`define VNU_LUT_AW 3

// one lut word
`define VNU_DATA_W 8

// credits granted by the downstream vnu memory after reset
`define VNU_CREDITS 4

// pipelined update passes after the initial load
`define VNU_MAX_ITER 3

`endif

// ==== logic/vnu_pkg.sv ====
`include "vnu_config.svh"

package vnu_pkg;

	// iteration controller states
	typedef enum logic [2:0] {
		IDLE,
		// initial load of the lut
		INIT_LOAD,
		// phase just toggled, read pass on its way
		PIPE_READ,
		// read pass and pipeline write in flight
		PIPE_LOAD,
		DONE
	} ctrl_state_e;

	// kind of write phase carried with every record
	typedef enum logic {
		LOAD_INIT,
		LOAD_PIPE
	} load_kind_e;

	// one write towards the vnu memory
	typedef struct packed {
		logic [`VNU_LUT_AW-1:0] addr;
		logic [`VNU_DATA_W-1:0] data;
		load_kind_e kind;
	} lut_wr_s;

endpackage

// ==== logic/vnu_iter_ctrl.sv ====
`timescale 1ns/1ps
`include "vnu_config.svh"

module vnu_iter_ctrl (
	input  logic read_clk,
	input  logic rstn,
	input  logic start_i,
	input  logic walk_done_i,
	output logic init_load_en_o,
	output logic iter_update_o,
	output logic done_o
);

	// wide enough for max_iter itself and never zero bits
	localparam int CNT_W = $clog2(`VNU_MAX_ITER + 2);
	localparam logic [CNT_W-1:0] LAST_PASS = CNT_W'(`VNU_MAX_ITER);

	vnu_pkg::ctrl_state_e state;
	// finished pipeline passes
	logic [CNT_W-1:0] pass_cnt;

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			state <= vnu_pkg::IDLE;
			pass_cnt <= '0;
			iter_update_o <= 1'b0;
		end else begin
			case (state)
				vnu_pkg::IDLE: begin
					if (start_i) begin
						state <= vnu_pkg::INIT_LOAD;
						pass_cnt <= '0;
					end
				end
				vnu_pkg::INIT_LOAD: begin
					// initial write walk finished
					// the toggle closes the write phase
					if (walk_done_i) begin
						state <= vnu_pkg::PIPE_READ;
						iter_update_o <= ~iter_update_o;
					end
				end
				vnu_pkg::PIPE_READ: begin
					// last pass done
					// toggle back before the sequencer sees it
					// so the closing toggle starts no further read pass
					if (pass_cnt == LAST_PASS) begin
						state <= vnu_pkg::DONE;
						iter_update_o <= ~iter_update_o;
					end else begin
						state <= vnu_pkg::PIPE_LOAD;
					end
				end
				vnu_pkg::PIPE_LOAD: begin
					// read walk and then pipeline write walk
					if (walk_done_i) begin
						state <= vnu_pkg::PIPE_READ;
						pass_cnt <= pass_cnt + 1'b1;
						iter_update_o <= ~iter_update_o;
					end
				end
				vnu_pkg::DONE: begin
					// held until reset
					state <= vnu_pkg::DONE;
				end
				default: begin
					state <= vnu_pkg::IDLE;
				end
			endcase
		end
	end

	// level request to the handshake while loading
	assign init_load_en_o = (state == vnu_pkg::INIT_LOAD);
	assign done_o = (state == vnu_pkg::DONE);

endmodule

// ==== logic/vnu_lut_rd_seq.sv ====
`timescale 1ns/1ps
`include "vnu_config.svh"

module vnu_lut_rd_seq (
	input  logic read_clk,
	input  logic rstn,
	input  logic vnu_wr_i,
	input  logic init_load_i,
	input  logic pipe_load_i,
	input  logic stall_i,
	input  logic phase_i,
	output logic [`VNU_LUT_AW-1:0] rd_addr_o,
	output logic rd_en_o,
	output logic rd_finish_o,
	output logic walk_done_o,
	output logic write_walk_o
);

	localparam int AW = `VNU_LUT_AW;
	localparam logic [AW-1:0] LAST_ADDR = AW'(`VNU_LUT_DEPTH - 1);

	logic busy;
	// write walk already done in this write phase
	logic walked;
	// phase value of the last read pass
	logic phase_seen;
	logic load_any;
	logic start_write;
	logic start_read;
	logic last_issue;
	// tracks the last write address through the update port stages
	logic [1:0] rec_sr;

	assign load_any = init_load_i | pipe_load_i;
	// one write walk per write phase
	assign start_write = load_any && !walked && !busy;
	// read pass once the write phase is fully closed
	assign start_read = (phase_i != phase_seen) && !vnu_wr_i && !load_any && !busy;
	assign last_issue = busy && !stall_i && (rd_addr_o == LAST_ADDR);

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			busy <= 1'b0;
			walked <= 1'b0;
			phase_seen <= 1'b0;
			write_walk_o <= 1'b0;
			rd_addr_o <= '0;
			rd_finish_o <= 1'b0;
			rec_sr <= '0;
			walk_done_o <= 1'b0;
		end else begin
			rd_finish_o <= last_issue && !write_walk_o;
			// last record leaves the port two cycles after its address
			rec_sr <= {rec_sr[0], last_issue && write_walk_o};
			walk_done_o <= rec_sr[1];
			if (!load_any) begin
				walked <= 1'b0;
			end
			if (start_write) begin
				busy <= 1'b1;
				walked <= 1'b1;
				write_walk_o <= 1'b1;
				rd_addr_o <= '0;
			end else if (start_read) begin
				busy <= 1'b1;
				phase_seen <= phase_i;
				write_walk_o <= 1'b0;
				rd_addr_o <= '0;
			end else if (busy && !stall_i) begin
				// stalled address holds and is read again
				if (last_issue) begin
					busy <= 1'b0;
				end else begin
					rd_addr_o <= rd_addr_o + 1'b1;
				end
			end
		end
	end

	assign rd_en_o = busy;

endmodule

// ==== logic/vnu_wr_update_handshake.sv ====
`timescale 1ns/1ps

module vnu_wr_update_handshake #(
	// synchroniser depth of at least 2
	parameter int CDC_DEPTH = 2
) (
	input  logic read_clk,
	input  logic rstn,
	input  logic iter_update_i,
	// read pass over the decomposed lut finished
	input  logic vnu_rd_finish_i,
	// controller sits in the initial load
	input  logic vnu_init_load_en_i,
	output logic vnu_wr_o,
	output logic init_load_o,
	output logic pipe_load_o
);

	// newest sample in bit 0
	logic [CDC_DEPTH-1:0] phase_sync;
	logic phase_toggle;
	logic req;
	logic open_wr;
	// kind of request that opened the phase
	vnu_pkg::load_kind_e req_kind;
	// vnu_wr sampled on falling edges
	logic [1:0] wr_trace;

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			phase_sync <= '0;
		end else begin
			phase_sync <= {phase_sync[CDC_DEPTH-2:0], iter_update_i};
		end
	end

	// toggle seen at the synchroniser output
	assign phase_toggle = phase_sync[CDC_DEPTH-1] ^ phase_sync[CDC_DEPTH-2];

	assign req = vnu_init_load_en_i | vnu_rd_finish_i;
	// no new phase until the flags of the last one are gone
	assign open_wr = req && !vnu_wr_o && !init_load_o && !pipe_load_o;

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			vnu_wr_o <= 1'b0;
			req_kind <= vnu_pkg::LOAD_INIT;
		end else begin
			if (phase_toggle) begin
				vnu_wr_o <= 1'b0;
			end else if (open_wr) begin
				vnu_wr_o <= 1'b1;
				req_kind <= vnu_init_load_en_i ? vnu_pkg::LOAD_INIT : vnu_pkg::LOAD_PIPE;
			end
		end
	end

	always_ff @(negedge read_clk or negedge rstn) begin
		if (!rstn) begin
			wr_trace <= 2'b00;
		end else begin
			wr_trace <= {wr_trace[0], vnu_wr_o};
		end
	end

	// flags follow vnu_wr by one cycle
	// cleared on the cycle after vnu_wr falls
	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			init_load_o <= 1'b0;
			pipe_load_o <= 1'b0;
		end else begin
			if (wr_trace == 2'b10) begin
				init_load_o <= 1'b0;
				pipe_load_o <= 1'b0;
			end else if (vnu_wr_o && !init_load_o && !pipe_load_o) begin
				init_load_o <= (req_kind == vnu_pkg::LOAD_INIT);
				pipe_load_o <= (req_kind == vnu_pkg::LOAD_PIPE);
			end
		end
	end

endmodule

// ==== logic/vnu_lut_update_port.sv ====
`timescale 1ns/1ps
`include "vnu_config.svh"

module vnu_lut_update_port (
	input  logic read_clk,
	input  logic rstn,
	input  logic rd_en_i,
	input  logic write_walk_i,
	input  logic pipe_load_i,
	input  logic [`VNU_LUT_AW-1:0] rd_addr_i,
	input  logic [`VNU_DATA_W-1:0] rd_data_i,
	input  logic credit_i,
	output vnu_pkg::lut_wr_s wr_rec_o,
	output logic wr_valid_o,
	output logic stall_o
);

	// one spare bit for the in flight reservations
	localparam int CW = $clog2(`VNU_CREDITS + 1) + 1;

	logic [CW-1:0] credit_cnt;
	// records issued but not yet spent
	logic [CW-1:0] reserved;
	logic issue;
	logic issue_q;
	// address lined up with the returning data
	logic [`VNU_LUT_AW-1:0] addr_q;
	vnu_pkg::load_kind_e kind_q;

	assign reserved = CW'(issue_q) + CW'(wr_valid_o);
	// read passes are never held back
	assign stall_o = write_walk_i && (credit_cnt <= reserved);
	assign issue = rd_en_i && write_walk_i && !stall_o;

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			issue_q <= 1'b0;
			wr_valid_o <= 1'b0;
			credit_cnt <= CW'(`VNU_CREDITS);
		end else begin
			issue_q <= issue;
			wr_valid_o <= issue_q;
			// spend on send and refill on each returned credit
			credit_cnt <= credit_cnt - CW'(wr_valid_o) + CW'(credit_i);
		end
	end

	// data path
	always_ff @(posedge read_clk) begin
		addr_q <= rd_addr_i;
		kind_q <= pipe_load_i ? vnu_pkg::LOAD_PIPE : vnu_pkg::LOAD_INIT;
		if (issue_q) begin
			wr_rec_o.addr <= addr_q;
			wr_rec_o.data <= rd_data_i;
			wr_rec_o.kind <= kind_q;
		end
	end

endmodule

// ==== logic/vnu_update_top.sv ====
`timescale 1ns/1ps
`include "vnu_config.svh"

module vnu_update_top (
	input  logic read_clk,
	input  logic rstn,
	input  logic start_i,
	input  logic [`VNU_DATA_W-1:0] rd_data_i,
	input  logic credit_i,
	output logic [`VNU_LUT_AW-1:0] rd_addr_o,
	output logic rd_en_o,
	output vnu_pkg::lut_wr_s wr_rec_o,
	output logic wr_valid_o,
	output logic vnu_wr_o,
	output logic init_load_o,
	output logic pipe_load_o,
	output logic done_o
);

	// controller to handshake
	logic init_load_en;
	logic iter_update;
	// sequencer status
	logic rd_finish;
	logic walk_done;
	logic write_walk;
	// credit back pressure
	logic stall;

	vnu_iter_ctrl u_ctrl (
		.read_clk(read_clk),
		.rstn(rstn),
		.start_i(start_i),
		.walk_done_i(walk_done),
		.init_load_en_o(init_load_en),
		.iter_update_o(iter_update),
		.done_o(done_o)
	);

	vnu_wr_update_handshake #(
		.CDC_DEPTH(`VNU_CDC_DEPTH)
	) u_hs (
		.read_clk(read_clk),
		.rstn(rstn),
		.iter_update_i(iter_update),
		.vnu_rd_finish_i(rd_finish),
		.vnu_init_load_en_i(init_load_en),
		.vnu_wr_o(vnu_wr_o),
		.init_load_o(init_load_o),
		.pipe_load_o(pipe_load_o)
	);

	vnu_lut_rd_seq u_seq (
		.read_clk(read_clk),
		.rstn(rstn),
		.vnu_wr_i(vnu_wr_o),
		.init_load_i(init_load_o),
		.pipe_load_i(pipe_load_o),
		.stall_i(stall),
		.phase_i(iter_update),
		.rd_addr_o(rd_addr_o),
		.rd_en_o(rd_en_o),
		.rd_finish_o(rd_finish),
		.walk_done_o(walk_done),
		.write_walk_o(write_walk)
	);

	vnu_lut_update_port u_port (
		.read_clk(read_clk),
		.rstn(rstn),
		.rd_en_i(rd_en_o),
		.write_walk_i(write_walk),
		.pipe_load_i(pipe_load_o),
		.rd_addr_i(rd_addr_o),
		.rd_data_i(rd_data_i),
		.credit_i(credit_i),
		.wr_rec_o(wr_rec_o),
		.wr_valid_o(wr_valid_o),
		.stall_o(stall)
	);

endmodule

// ==== testbench/vnu_update_assert.sv ====
`timescale 1ns/1ps
`include "vnu_config.svh"

module vnu_update_assert (
	input logic read_clk,
	input logic rstn,
	input logic credit_i,
	input logic rd_en_i,
	input logic wr_valid_i,
	input logic vnu_wr_i,
	input logic init_load_i,
	input logic pipe_load_i,
	input logic done_i
);

	// two spare bits so an overshoot stays visible
	localparam int CW = $clog2(`VNU_CREDITS + 1) + 2;
	localparam logic [CW-1:0] LIMIT = CW'(`VNU_CREDITS);

	// failed assertions so far, read by the testbench
	int fail_cnt = 0;
	// records sent minus credits returned
	logic [CW-1:0] in_flight;

	always_ff @(posedge read_clk or negedge rstn) begin
		if (!rstn) begin
			in_flight <= '0;
		end else begin
			in_flight <= in_flight + CW'(wr_valid_i) - CW'(credit_i);
		end
	end

	// quiet outputs in reset and in the first cycle after it
	reset_quiet: assert property (@(posedge read_clk)
		(!rstn || $past(!rstn)) |->
		!(rd_en_i || wr_valid_i || vnu_wr_i || init_load_i || pipe_load_i || done_i))
	else begin
		fail_cnt = fail_cnt + 1;
		$error("outputs active during reset or in the cycle after it");
	end

	// one load kind at a time
	flags_exclusive: assert property (@(posedge read_clk) disable iff (!rstn)
		!(init_load_i && pipe_load_i))
	else begin
		fail_cnt = fail_cnt + 1;
		$error("init_load and pipe_load high together");
	end

	// flags may outlive vnu_wr by one cycle only
	flags_in_phase: assert property (@(posedge read_clk) disable iff (!rstn)
		(init_load_i || pipe_load_i) |-> (vnu_wr_i || $past(vnu_wr_i)))
	else begin
		fail_cnt = fail_cnt + 1;
		$error("load flag high outside the write phase");
	end

	record_in_phase: assert property (@(posedge read_clk) disable iff (!rstn)
		wr_valid_i |-> (vnu_wr_i && (init_load_i || pipe_load_i)))
	else begin
		fail_cnt = fail_cnt + 1;
		$error("record sent outside a tagged write phase");
	end

	// no send once all credits are out
	credit_guard: assert property (@(posedge read_clk) disable iff (!rstn)
		wr_valid_i |-> (in_flight < LIMIT))
	else begin
		fail_cnt = fail_cnt + 1;
		$error("record sent with no credit left");
	end

	quiet_after_done: assert property (@(posedge read_clk) disable iff (!rstn)
		done_i |-> !wr_valid_i)
	else begin
		fail_cnt = fail_cnt + 1;
		$error("record sent after done");
	end

endmodule

bind vnu_update_top vnu_update_assert u_assert (
	.read_clk(read_clk),
	.rstn(rstn),
	.credit_i(credit_i),
	.rd_en_i(rd_en_o),
	.wr_valid_i(wr_valid_o),
	.vnu_wr_i(vnu_wr_o),
	.init_load_i(init_load_o),
	.pipe_load_i(pipe_load_o),
	.done_i(done_o)
);

// ==== testbench/tb_vnu_update.sv ====
`timescale 1ns/1ps
`include "vnu_config.svh"

module tb_vnu_update;

	localparam int DEPTH = `VNU_LUT_DEPTH;
	localparam int AW = `VNU_LUT_AW;
	localparam int DW = `VNU_DATA_W;
	localparam int CREDITS = `VNU_CREDITS;
	// initial load plus every pipeline pass
	localparam int TOTAL = DEPTH * (1 + `VNU_MAX_ITER);
	localparam int DONE_TIMEOUT = 4000;
	localparam int DRAIN_CYCLES = 20;

	logic read_clk;
	logic rstn;
	logic start_i;
	logic [DW-1:0] rd_data_i;
	logic credit_i;
	logic [AW-1:0] rd_addr_o;
	logic rd_en_o;
	vnu_pkg::lut_wr_s wr_rec_o;
	logic wr_valid_o;
	logic vnu_wr_o;
	logic init_load_o;
	logic pipe_load_o;
	logic done_o;

	// external memory contents
	logic [DW-1:0] mem [DEPTH];
	int sent = 0;
	int returned = 0;
	// cycle count kept by the credit sink
	int unsigned cyc = 0;
	// cycles at which pending credits go back
	int unsigned due_q [$];
	logic done_seen = 1'b0;

	vnu_update_top DUT (
		.read_clk(read_clk),
		.rstn(rstn),
		.start_i(start_i),
		.rd_data_i(rd_data_i),
		.credit_i(credit_i),
		.rd_addr_o(rd_addr_o),
		.rd_en_o(rd_en_o),
		.wr_rec_o(wr_rec_o),
		.wr_valid_o(wr_valid_o),
		.vnu_wr_o(vnu_wr_o),
		.init_load_o(init_load_o),
		.pipe_load_o(pipe_load_o),
		.done_o(done_o)
	);

	task automatic stop_with_failure();
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			$display("error: test %s expected %0d actual %0d", name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_at_most(input string name, input int limit, input int actual);
		assert (actual <= limit) else begin
			$display("error: test %s expected at most %0d actual %0d", name, limit, actual);
			stop_with_failure();
		end
	endtask

	initial begin
		read_clk = 1'b0;
		forever #50 read_clk = ~read_clk;
	end

	// read data one cycle after the address
	initial begin : memory_model
		logic [AW-1:0] addr_q;
		logic en_q;
		rd_data_i = '0;
		forever begin
			@(negedge read_clk);
			addr_q = rd_addr_o;
			en_q = rd_en_o;
			@(posedge read_clk);
			#10;
			if (en_q) begin
				rd_data_i = mem[addr_q];
			end
		end
	end

	// at most one credit pulse per cycle with the oldest first
	initial begin : credit_sink
		credit_i = 1'b0;
		forever begin
			@(posedge read_clk);
			#10;
			cyc = cyc + 1;
			if (due_q.size() != 0 && due_q[0] <= cyc) begin
				void'(due_q.pop_front());
				credit_i = 1'b1;
			end else begin
				credit_i = 1'b0;
			end
		end
	end

	// mid cycle sampling of records and credits
	initial begin : record_monitor
		int exp_addr;
		vnu_pkg::load_kind_e exp_kind;
		forever begin
			@(negedge read_clk);
			check_value("bound_assertions", 0, DUT.u_assert.fail_cnt);
			if (rstn) begin
				if (done_o && !done_seen) begin
					check_value("records_before_done", TOTAL, sent);
					done_seen = 1'b1;
				end
				if (wr_valid_o) begin
					check_value("record_after_done", 0, int'(done_o));
					// this cycle's credit is not yet usable
					check_at_most("credits_in_flight", CREDITS - 1, sent - returned);
					check_at_most("record_count", TOTAL - 1, sent);
					exp_addr = sent % DEPTH;
					exp_kind = (sent < DEPTH) ? vnu_pkg::LOAD_INIT : vnu_pkg::LOAD_PIPE;
					check_value("record_addr", exp_addr, int'(wr_rec_o.addr));
					check_value("record_kind", int'(exp_kind), int'(wr_rec_o.kind));
					check_value("record_data", int'(mem[wr_rec_o.addr]), int'(wr_rec_o.data));
					due_q.push_back(cyc + $urandom_range(5, 0));
					sent = sent + 1;
				end
				if (credit_i) begin
					returned = returned + 1;
				end
			end
		end
	end

	initial begin : stimulus
		int waited;
		rstn = 1'b0;
		start_i = 1'b0;
		void'($urandom(32'hfff2));
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = DW'($urandom());
		end
		repeat (2) @(posedge read_clk);
		#10;
		rstn = 1'b1;
		repeat (2) @(posedge read_clk);
		#10;
		start_i = 1'b1;
		@(posedge read_clk);
		#10;
		start_i = 1'b0;
		// whole decode with latency set by the credit return
		waited = 0;
		while (!done_o && waited < DONE_TIMEOUT) begin
			@(negedge read_clk);
			waited = waited + 1;
		end
		if (!done_o) begin
			$display("error: done_o stayed low for %0d cycles after start", DONE_TIMEOUT);
			stop_with_failure();
		end
		// watch for stray records after done
		repeat (DRAIN_CYCLES) @(negedge read_clk);
		if (DUT.u_assert.fail_cnt == 0 && sent == TOTAL) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("error: test final_count expected %0d records actual %0d", TOTAL, sent);
			stop_with_failure();
		end
	end

endmodule

// ==== src.f ====
+incdir+logic
logic/vnu_pkg.sv
logic/vnu_iter_ctrl.sv
logic/vnu_lut_rd_seq.sv
logic/vnu_wr_update_handshake.sv
logic/vnu_lut_update_port.sv
logic/vnu_update_top.sv
testbench/vnu_update_assert.sv
testbench/tb_vnu_update.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP := tb_vnu_update
FILELIST := src.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS := --binary --timing
SIM_ARGS := +verilator+error+limit+100
BUILD_DIR := obj_dir
PASS_MSG := Simulation PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)
